// File: renameStage.f
+incdir+include
source/renamePkg.sv
source/renameMapTable.sv
source/groupDependency.sv
source/renameOutputStage.sv
source/renameStage.sv
testbench/renameStageTb.sv

// File: run.sh
#!/bin/sh
# Builds the rename stage testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

buildDir=build
logFile="$buildDir/sim.log"

mkdir -p "$buildDir"
if [ $? -ne 0 ]; then
    echo "cannot create $buildDir"
    exit 1
fi

verilator --binary --timing --top-module renameStageTb \
    -Mdir "$buildDir/obj" -f renameStage.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"$buildDir/obj/VrenameStageTb" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "TEST FAILED" "$logFile"; then
    echo "simulation reported failures, see $logFile"
    exit 1
fi

exit 0

// File: source/groupDependency.sv
module groupDependency (
    // incoming group.
    input  renamePkg::archRegT srcArch [renamePkg::NumWays][renamePkg::NumSrcs],
    input  logic               dstValid [renamePkg::NumWays],
    input  renamePkg::archRegT dstArch [renamePkg::NumWays],
    input  renamePkg::physRegT dstPhys [renamePkg::NumWays],

    // table values read at the group's architectural numbers.
    input  renamePkg::physRegT tableSrcPhys [renamePkg::NumWays][renamePkg::NumSrcs],
    input  renamePkg::physRegT tableDstPhys [renamePkg::NumWays],

    // values after in-group forwarding.
    output renamePkg::physRegT resolvedSrcPhys [renamePkg::NumWays][renamePkg::NumSrcs],
    output renamePkg::physRegT resolvedPrevPhys [renamePkg::NumWays]
);

    ////////////////////////////////////////////////////////////
    // forwarding from earlier ways
    ////////////////////////////////////////////////////////////

    // scans the ways below `way` for a valid destination that names `arch`.
    // Lower ways are checked first and a later hit overrides, so the
    // nearest earlier way ends up as the result.
    function automatic renamePkg::physRegT forwardPhys(
        input renamePkg::archRegT arch,
        input int                 way,
        input renamePkg::physRegT tableValue
    );
        renamePkg::physRegT result;
        result = tableValue;
        for (int e = 0; e < renamePkg::NumWays; e++) begin
            if (e < way && dstValid[e] && (dstArch[e] == arch)) begin
                result = dstPhys[e];
            end
        end
        return result;
    endfunction

    always_comb begin
        for (int w = 0; w < renamePkg::NumWays; w++) begin
            for (int s = 0; s < renamePkg::NumSrcs; s++) begin
                resolvedSrcPhys[w][s] = forwardPhys(srcArch[w][s], w, tableSrcPhys[w][s]);
            end

            // the mapping this way replaces may itself come from an earlier
            // way of the group and not from the table.
            resolvedPrevPhys[w] = forwardPhys(dstArch[w], w, tableDstPhys[w]);
        end
    end

endmodule

// File: source/renameMapTable.sv
module renameMapTable (
    input  logic               Clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               stall,

    // lookup addresses.
    input  renamePkg::archRegT srcArch [renamePkg::NumWays][renamePkg::NumSrcs],

    // group writes.
    input  logic               dstValid [renamePkg::NumWays],
    input  renamePkg::archRegT dstArch [renamePkg::NumWays],
    input  renamePkg::physRegT dstPhys [renamePkg::NumWays],

    // lookup results, current table contents only.
    output renamePkg::physRegT tableSrcPhys [renamePkg::NumWays][renamePkg::NumSrcs],
    output renamePkg::physRegT tableDstPhys [renamePkg::NumWays]
);

    renamePkg::physRegT mapTable [renamePkg::NumArchRegs];

    ////////////////////////////////////////////////////////////
    // table update
    ////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (rst || flush) begin
            for (int i = 0; i < renamePkg::NumArchRegs; i++) begin
                mapTable[i] <= renamePkg::identityPhys(renamePkg::archRegT'(i));
            end
        end else if (!stall) begin
            // ways are walked in order, so when two ways name the same
            // register the later assignment is the one that lands.
            for (int w = 0; w < renamePkg::NumWays; w++) begin
                if (dstValid[w]) begin
                    mapTable[dstArch[w]] <= dstPhys[w];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // lookups
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < renamePkg::NumWays; w++) begin
            for (int s = 0; s < renamePkg::NumSrcs; s++) begin
                tableSrcPhys[w][s] = mapTable[srcArch[w][s]];
            end
            tableDstPhys[w] = mapTable[dstArch[w]];   // old mapping of the destination.
        end
    end

endmodule

// File: source/renameOutputStage.sv
module renameOutputStage (
    input  logic               Clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               stall,

    input  logic               srcValid [renamePkg::NumWays][renamePkg::NumSrcs],
    input  logic               dstValid [renamePkg::NumWays],
    input  renamePkg::physRegT dstPhys [renamePkg::NumWays],
    input  renamePkg::physRegT resolvedSrcPhys [renamePkg::NumWays][renamePkg::NumSrcs],
    input  renamePkg::physRegT resolvedPrevPhys [renamePkg::NumWays],

    output logic               outSrcValid [renamePkg::NumWays][renamePkg::NumSrcs],
    output renamePkg::physRegT outSrcPhys [renamePkg::NumWays][renamePkg::NumSrcs],
    output logic               outDstValid [renamePkg::NumWays],
    output renamePkg::physRegT outDstPhys [renamePkg::NumWays],
    output logic               prevValid [renamePkg::NumWays],
    output renamePkg::physRegT prevPhys [renamePkg::NumWays]
);

    ////////////////////////////////////////////////////////////
    // renamed group register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (rst || flush || stall) begin
            // a dropped group shows up downstream as an empty one.
            for (int w = 0; w < renamePkg::NumWays; w++) begin
                for (int s = 0; s < renamePkg::NumSrcs; s++) begin
                    outSrcValid[w][s] <= 1'b0;
                    outSrcPhys[w][s]  <= '0;
                end
                outDstValid[w] <= 1'b0;
                outDstPhys[w]  <= '0;
                prevValid[w]   <= 1'b0;
                prevPhys[w]    <= '0;
            end
        end else begin
            for (int w = 0; w < renamePkg::NumWays; w++) begin
                for (int s = 0; s < renamePkg::NumSrcs; s++) begin
                    outSrcValid[w][s] <= srcValid[w][s];
                    outSrcPhys[w][s]  <= srcValid[w][s] ? resolvedSrcPhys[w][s] : '0;
                end

                outDstValid[w] <= dstValid[w];
                outDstPhys[w]  <= dstValid[w] ? dstPhys[w] : '0;

                // only a real destination frees an old register at retire.
                prevValid[w] <= dstValid[w];
                prevPhys[w]  <= dstValid[w] ? resolvedPrevPhys[w] : '0;
            end
        end
    end

endmodule

// File: source/renamePkg.sv
package renamePkg;

    ////////////////////////////////////////////////////////////
    // rename group geometry
    ////////////////////////////////////////////////////////////

    localparam int NumWays = 4;         // instructions renamed per cycle.
    localparam int NumSrcs = 2;         // source operands per instruction.

    ////////////////////////////////////////////////////////////
    // register files
    ////////////////////////////////////////////////////////////

    localparam int NumArchRegs = 32;
    localparam int NumPhysRegs = 128;

    // widths follow from the register counts.
    localparam int ArchBits = $clog2(NumArchRegs);
    localparam int PhysBits = $clog2(NumPhysRegs);

    typedef logic [ArchBits-1:0] archRegT;
    typedef logic [PhysBits-1:0] physRegT;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    // after reset or flush every architectural register maps to the
    // physical register with the same number.
    function automatic physRegT identityPhys(
        input archRegT arch
    );
        physRegT phys;
        phys = physRegT'(arch);
        return phys;
    endfunction

endpackage

// File: source/renameStage.sv
module renameStage (
    input  logic               Clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               stall,

    // from decode.
    input  logic               srcValid [renamePkg::NumWays][renamePkg::NumSrcs],
    input  renamePkg::archRegT srcArch [renamePkg::NumWays][renamePkg::NumSrcs],
    input  logic               dstValid [renamePkg::NumWays],
    input  renamePkg::archRegT dstArch [renamePkg::NumWays],

    // from the free list.
    input  renamePkg::physRegT dstPhys [renamePkg::NumWays],

    // renamed group, one cycle after it is sampled.
    output logic               outSrcValid [renamePkg::NumWays][renamePkg::NumSrcs],
    output renamePkg::physRegT outSrcPhys [renamePkg::NumWays][renamePkg::NumSrcs],
    output logic               outDstValid [renamePkg::NumWays],
    output renamePkg::physRegT outDstPhys [renamePkg::NumWays],

    // old mappings for the retire logic to release.
    output logic               prevValid [renamePkg::NumWays],
    output renamePkg::physRegT prevPhys [renamePkg::NumWays]
);

    ////////////////////////////////////////////////////////////
    // internal wires
    ////////////////////////////////////////////////////////////

    renamePkg::physRegT tableSrcPhys [renamePkg::NumWays][renamePkg::NumSrcs];
    renamePkg::physRegT tableDstPhys [renamePkg::NumWays];

    renamePkg::physRegT resolvedSrcPhys [renamePkg::NumWays][renamePkg::NumSrcs];
    renamePkg::physRegT resolvedPrevPhys [renamePkg::NumWays];

    ////////////////////////////////////////////////////////////
    // map table
    ////////////////////////////////////////////////////////////

    renameMapTable uMapTable (
        .Clk          (Clk),
        .rst          (rst),
        .flush        (flush),
        .stall        (stall),
        .srcArch      (srcArch),
        .dstValid     (dstValid),
        .dstArch      (dstArch),
        .dstPhys      (dstPhys),
        .tableSrcPhys (tableSrcPhys),
        .tableDstPhys (tableDstPhys)
    );

    ////////////////////////////////////////////////////////////
    // in-group dependences
    ////////////////////////////////////////////////////////////

    groupDependency uGroupDep (
        .srcArch          (srcArch),
        .dstValid         (dstValid),
        .dstArch          (dstArch),
        .dstPhys          (dstPhys),
        .tableSrcPhys     (tableSrcPhys),
        .tableDstPhys     (tableDstPhys),
        .resolvedSrcPhys  (resolvedSrcPhys),
        .resolvedPrevPhys (resolvedPrevPhys)
    );

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////

    renameOutputStage uOutputStage (
        .Clk              (Clk),
        .rst              (rst),
        .flush            (flush),
        .stall            (stall),
        .srcValid         (srcValid),
        .dstValid         (dstValid),
        .dstPhys          (dstPhys),
        .resolvedSrcPhys  (resolvedSrcPhys),
        .resolvedPrevPhys (resolvedPrevPhys),
        .outSrcValid      (outSrcValid),
        .outSrcPhys       (outSrcPhys),
        .outDstValid      (outDstValid),
        .outDstPhys       (outDstPhys),
        .prevValid        (prevValid),
        .prevPhys         (prevPhys)
    );

endmodule

// File: include/renameModel.svh
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

// model copy of the architectural map.
renamePkg::physRegT modelMap [renamePkg::NumArchRegs];

function automatic void modelReset();
    for (int i = 0; i < renamePkg::NumArchRegs; i++) begin
        modelMap[i] = renamePkg::identityPhys(renamePkg::archRegT'(i));
    end
endfunction

// expected outputs for one group; the map is updated only when the group
// is accepted. Renaming ways one at a time on a working copy gives the
// nearest-earlier-way forwarding and the last-writer-wins table update.
function automatic void modelRename(
    input  logic               flushIn,
    input  logic               stallIn,
    input  logic               srcValidIn [renamePkg::NumWays][renamePkg::NumSrcs],
    input  renamePkg::archRegT srcArchIn [renamePkg::NumWays][renamePkg::NumSrcs],
    input  logic               dstValidIn [renamePkg::NumWays],
    input  renamePkg::archRegT dstArchIn [renamePkg::NumWays],
    input  renamePkg::physRegT dstPhysIn [renamePkg::NumWays],
    output logic               expSrcValid [renamePkg::NumWays][renamePkg::NumSrcs],
    output renamePkg::physRegT expSrcPhys [renamePkg::NumWays][renamePkg::NumSrcs],
    output logic               expDstValid [renamePkg::NumWays],
    output renamePkg::physRegT expDstPhys [renamePkg::NumWays],
    output logic               expPrevValid [renamePkg::NumWays],
    output renamePkg::physRegT expPrevPhys [renamePkg::NumWays]
);
    renamePkg::physRegT work [renamePkg::NumArchRegs];
    logic accept;
    accept = !flushIn && !stallIn;
    work = modelMap;
    for (int w = 0; w < renamePkg::NumWays; w++) begin
        for (int s = 0; s < renamePkg::NumSrcs; s++) begin
            expSrcValid[w][s] = accept && srcValidIn[w][s];
            expSrcPhys[w][s]  = expSrcValid[w][s] ? work[srcArchIn[w][s]] : '0;
        end
        expDstValid[w]  = accept && dstValidIn[w];
        expDstPhys[w]   = expDstValid[w] ? dstPhysIn[w] : '0;
        expPrevValid[w] = expDstValid[w];
        expPrevPhys[w]  = expDstValid[w] ? work[dstArchIn[w]] : '0;
        if (dstValidIn[w]) begin
            work[dstArchIn[w]] = dstPhysIn[w];
        end
    end
    if (flushIn) begin
        modelReset();
    end else if (accept) begin
        modelMap = work;
    end
endfunction

`endif

// File: testbench/renameStageTb.sv
module renameStageTb;

    localparam int MaxCycles = 4000;    // about 1.5 times the length of all tests.
    localparam int DepPool   = 4;       // small register pool so that ways collide.

    localparam int ModeEmpty = 0;       // no destinations.
    localparam int ModeIndep = 1;
    localparam int ModeDep   = 2;
    localparam int ModeKeep  = 3;       // present the previous group again.

    logic               Clk;
    logic               rst;
    logic               flush;
    logic               stall;
    logic               srcValid [renamePkg::NumWays][renamePkg::NumSrcs];
    renamePkg::archRegT srcArch [renamePkg::NumWays][renamePkg::NumSrcs];
    logic               dstValid [renamePkg::NumWays];
    renamePkg::archRegT dstArch [renamePkg::NumWays];
    renamePkg::physRegT dstPhys [renamePkg::NumWays];

    logic               outSrcValid [renamePkg::NumWays][renamePkg::NumSrcs];
    renamePkg::physRegT outSrcPhys [renamePkg::NumWays][renamePkg::NumSrcs];
    logic               outDstValid [renamePkg::NumWays];
    renamePkg::physRegT outDstPhys [renamePkg::NumWays];
    logic               prevValid [renamePkg::NumWays];
    renamePkg::physRegT prevPhys [renamePkg::NumWays];

    // expected outputs of the group sampled at the last rising edge.
    logic               expSrcValid [renamePkg::NumWays][renamePkg::NumSrcs];
    renamePkg::physRegT expSrcPhys [renamePkg::NumWays][renamePkg::NumSrcs];
    logic               expDstValid [renamePkg::NumWays];
    renamePkg::physRegT expDstPhys [renamePkg::NumWays];
    logic               expPrevValid [renamePkg::NumWays];
    renamePkg::physRegT expPrevPhys [renamePkg::NumWays];

    int   cycleCount;
    int   errorCount;
    int   checkCount;
    int   testsRun;
    int   testsFailed;
    int   testErrStart;
    int   presentedGroups;
    int   checkedGroups;
    logic armed;

    `include "renameModel.svh"

    renameStage u_dut (
        .Clk         (Clk),
        .rst         (rst),
        .flush       (flush),
        .stall       (stall),
        .srcValid    (srcValid),
        .srcArch     (srcArch),
        .dstValid    (dstValid),
        .dstArch     (dstArch),
        .dstPhys     (dstPhys),
        .outSrcValid (outSrcValid),
        .outSrcPhys  (outSrcPhys),
        .outDstValid (outDstValid),
        .outDstPhys  (outDstPhys),
        .prevValid   (prevValid),
        .prevPhys    (prevPhys)
    );

    ////////////////////////////////////////////////////////////
    // clock and timeout
    ////////////////////////////////////////////////////////////

    always #2 Clk = ~Clk;

    always @(posedge Clk) begin
        cycleCount++;
        if (cycleCount >= MaxCycles) begin
            $display("timeout: the run did not finish within %0d cycles", MaxCycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // checker
    ////////////////////////////////////////////////////////////

    task automatic logMismatch(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        $display("CHECK FAILED %s: got %0h, expected %0h", what, got, expected);
        errorCount++;
    endtask

    task automatic expectZero(input string what, input logic [31:0] got);
        checkCount++;
        if (got !== 32'h0) begin
            logMismatch(what, got, 32'h0);
        end
    endtask

    // outputs settle at the rising edge, so they are compared a time unit later.
    always begin
        @(posedge Clk);
        #1;
        if (armed) begin
            for (int w = 0; w < renamePkg::NumWays; w++) begin
                for (int s = 0; s < renamePkg::NumSrcs; s++) begin
                    if (outSrcValid[w][s] !== expSrcValid[w][s]) begin
                        logMismatch($sformatf("outSrcValid[%0d][%0d]", w, s),
                                    32'(outSrcValid[w][s]), 32'(expSrcValid[w][s]));
                    end
                    if (outSrcPhys[w][s] !== expSrcPhys[w][s]) begin
                        logMismatch($sformatf("outSrcPhys[%0d][%0d]", w, s),
                                    32'(outSrcPhys[w][s]), 32'(expSrcPhys[w][s]));
                    end
                end
                if (outDstValid[w] !== expDstValid[w]) begin
                    logMismatch($sformatf("outDstValid[%0d]", w),
                                32'(outDstValid[w]), 32'(expDstValid[w]));
                end
                if (outDstPhys[w] !== expDstPhys[w]) begin
                    logMismatch($sformatf("outDstPhys[%0d]", w),
                                32'(outDstPhys[w]), 32'(expDstPhys[w]));
                end
                if (prevValid[w] !== expPrevValid[w]) begin
                    logMismatch($sformatf("prevValid[%0d]", w),
                                32'(prevValid[w]), 32'(expPrevValid[w]));
                end
                if (prevPhys[w] !== expPrevPhys[w]) begin
                    logMismatch($sformatf("prevPhys[%0d]", w),
                                32'(prevPhys[w]), 32'(expPrevPhys[w]));
                end
            end
            checkCount += renamePkg::NumWays * (2 * renamePkg::NumSrcs + 4);
            checkedGroups++;
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    function automatic renamePkg::archRegT randomArch(input int pool);
        return renamePkg::archRegT'($urandom % pool);
    endfunction

    // true when a way below `way` already writes `arch`.
    function automatic logic namedEarlier(input renamePkg::archRegT arch, input int way);
        logic hit;
        hit = 1'b0;
        for (int e = 0; e < way; e++) begin
            if (dstValid[e] && dstArch[e] == arch) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic fillGroup(input int mode);
        for (int w = 0; w < renamePkg::NumWays; w++) begin
            dstPhys[w] = renamePkg::physRegT'($urandom);
            if (mode == ModeEmpty) begin
                dstValid[w] = 1'b0;
                dstArch[w]  = randomArch(renamePkg::NumArchRegs);
            end else if (mode == ModeDep) begin
                dstValid[w] = ($urandom % 4) != 0;
                dstArch[w]  = randomArch(DepPool);
            end else begin
                dstValid[w] = 1'b1;
                do begin
                    dstArch[w] = randomArch(renamePkg::NumArchRegs);
                end while (namedEarlier(dstArch[w], w));
            end
            for (int s = 0; s < renamePkg::NumSrcs; s++) begin
                srcValid[w][s] = 1'($urandom);
                if (mode == ModeDep) begin
                    srcArch[w][s] = randomArch(DepPool);
                end else begin
                    do begin
                        srcArch[w][s] = randomArch(renamePkg::NumArchRegs);
                    end while (mode == ModeIndep && namedEarlier(srcArch[w][s], w));
                end
            end
        end
    endtask

    // inputs are in place; work out what the DUT must return one cycle later.
    task automatic launchGroup(input logic doFlush, input logic doStall);
        flush = doFlush;
        stall = doStall;
        modelRename(flush, stall, srcValid, srcArch, dstValid, dstArch, dstPhys,
                    expSrcValid, expSrcPhys, expDstValid, expDstPhys,
                    expPrevValid, expPrevPhys);
        presentedGroups++;
        armed = 1'b1;
    endtask

    task automatic presentGroup(input int mode, input logic doFlush, input logic doStall);
        @(negedge Clk);
        if (mode != ModeKeep) begin
            fillGroup(mode);
        end
        launchGroup(doFlush, doStall);
    endtask

    // every way reads and writes r5, with new registers 0x40 to 0x43.
    task automatic presentSameDestGroup(input logic writes);
        @(negedge Clk);
        for (int w = 0; w < renamePkg::NumWays; w++) begin
            srcValid[w][0] = 1'b1;
            srcArch[w][0]  = 5'd5;
            srcValid[w][1] = 1'b0;
            srcArch[w][1]  = 5'd0;
            dstValid[w]    = writes;
            dstArch[w]     = 5'd5;
            dstPhys[w]     = renamePkg::physRegT'(8'h40 + w);
        end
        launchGroup(1'b0, 1'b0);
    endtask

    task automatic waitChecked();
        wait (checkedGroups == presentedGroups);
    endtask

    task automatic finishTest(input string name);
        waitChecked();
        testsRun++;
        if (errorCount != testErrStart) begin
            testsFailed++;
        end
        $display("test %0d (%s) done with %0d errors", testsRun, name, errorCount - testErrStart);
        testErrStart = errorCount;
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int r;
        int mode;
        void'($urandom(32'h3b0f6b1e));
        Clk = 1'b0;
        rst = 1'b1;
        flush = 1'b0;
        stall = 1'b0;
        armed = 1'b0;
        cycleCount = 0;
        errorCount = 0;
        checkCount = 0;
        testsRun = 0;
        testsFailed = 0;
        testErrStart = 0;
        presentedGroups = 0;
        checkedGroups = 0;
        for (int w = 0; w < renamePkg::NumWays; w++) begin
            for (int s = 0; s < renamePkg::NumSrcs; s++) begin
                srcValid[w][s] = 1'b0;
                srcArch[w][s]  = '0;
            end
            dstValid[w] = 1'b0;
            dstArch[w]  = '0;
            dstPhys[w]  = '0;
        end
        modelReset();

        repeat (4) @(posedge Clk);
        @(negedge Clk);
        rst = 1'b0;
        for (int w = 0; w < renamePkg::NumWays; w++) begin
            for (int s = 0; s < renamePkg::NumSrcs; s++) begin
                expectZero($sformatf("outSrcValid[%0d][%0d]", w, s), 32'(outSrcValid[w][s]));
                expectZero($sformatf("outSrcPhys[%0d][%0d]", w, s), 32'(outSrcPhys[w][s]));
            end
            expectZero($sformatf("outDstValid[%0d]", w), 32'(outDstValid[w]));
            expectZero($sformatf("outDstPhys[%0d]", w), 32'(outDstPhys[w]));
            expectZero($sformatf("prevValid[%0d]", w), 32'(prevValid[w]));
            expectZero($sformatf("prevPhys[%0d]", w), 32'(prevPhys[w]));
        end
        repeat (3) presentGroup(ModeEmpty, 1'b0, 1'b0);
        finishTest("reset and identity reads");

        repeat (500) presentGroup(ModeIndep, 1'b0, 1'b0);
        finishTest("independent groups");

        presentSameDestGroup(1'b1);
        presentSameDestGroup(1'b0);
        waitChecked();
        checkCount++;
        if (outSrcPhys[0][0] !== 7'h43) begin
            logMismatch("outSrcPhys[0][0]", 32'(outSrcPhys[0][0]), 32'h43);
        end
        repeat (40) presentGroup(ModeDep, 1'b0, 1'b0);
        finishTest("dependent groups");

        repeat (10) begin
            presentGroup(ModeDep, 1'b0, 1'b1);
            presentGroup(ModeKeep, 1'b0, 1'b0);
        end
        finishTest("stall and replay");

        repeat (30) presentGroup(ModeIndep, 1'b0, 1'b0);
        presentGroup(ModeIndep, 1'b1, 1'b0);
        repeat (10) presentGroup(ModeIndep, 1'b0, 1'b0);
        finishTest("flush in a stream");

        // now and then flush and stall come together, and flush must win.
        repeat (2000) begin
            r = $urandom % 100;
            mode = $urandom % 3;
            presentGroup(mode, r < 3, r >= 2 && r < 13);
        end
        finishTest("random mix");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 testsRun, testsFailed, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
